//--- compile.f
common/link_pkg.sv
auto_sync/auto_sync.sv
hdl/flit_packer.sv
lane_concat/lane_concat.sv
hdl/flit_unpacker.sv
hdl/link_top.sv
verification/link_tb.sv

//--- Bender.yml
package:
  name: d2d_link

sources:
  # Shared package first
  - common/link_pkg.sv
  # Link RTL
  - auto_sync/auto_sync.sv
  - hdl/flit_packer.sv
  - lane_concat/lane_concat.sv
  - hdl/flit_unpacker.sv
  - hdl/link_top.sv
  # Loopback testbench
  - target: test
    files:
      - verification/link_tb.sv

//--- verification/link_tb.sv
// Link loopback testbench
`timescale 1ns/1ns

module link_tb import link_pkg::*; ();

  localparam int MAX_CYCLES = 1200;

  // User fields of one flit, kept apart from the flit layout
  typedef struct packed {
    state_t  state;
    protid_t protid;
    data_t   data;
    logic    dvalid;
    crc_t    crc;
    logic    valid;
  } fields_t;

  logic    clk_wr = 1'b0;
  logic    rst;
  logic    tx_online;
  logic    rx_online;
  delay_t  delay_x_value;
  delay_t  delay_y_value;
  delay_t  delay_z_value;
  mrk_t    tx_mrk_userbit;
  logic    tx_stb_userbit;
  fields_t stim;
  lane_t   tx_lane [NUM_LANES];
  state_t  ustrm_state;
  protid_t ustrm_protid;
  data_t   ustrm_data;
  logic    ustrm_dvalid;
  crc_t    ustrm_crc;
  logic    ustrm_valid;

  integer  seed = 54;
  int      cycle_cnt = 0;

  // Reference model state
  int      tx_run;
  int      rx_run;
  int      tx_phase;
  logic    exp_tx_on;
  logic    exp_rx_on;
  logic    exp_stb;
  mrk_t    exp_mrk;
  logic    stb_due;
  fields_t exp_flit;
  fields_t exp_lane;
  fields_t exp_rx;
  fields_t exp_u;
  flit_t   exp_lane_bits;

  always #5 clk_wr = ~clk_wr;

  //////////////////////////////////////////////////////////////////////
  // DUT, transmit lanes looped back to receive
  //////////////////////////////////////////////////////////////////////
  link_top #(
    .MARKER_PERSISTENT (1'b1)
  ) DUT (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_phy0        (tx_lane[0]),
    .tx_phy1        (tx_lane[1]),
    .tx_phy2        (tx_lane[2]),
    .tx_phy3        (tx_lane[3]),
    .rx_phy0        (tx_lane[0]),
    .rx_phy1        (tx_lane[1]),
    .rx_phy2        (tx_lane[2]),
    .rx_phy3        (tx_lane[3]),
    .dstrm_state    (stim.state),
    .dstrm_protid   (stim.protid),
    .dstrm_data     (stim.data),
    .dstrm_dvalid   (stim.dvalid),
    .dstrm_crc      (stim.crc),
    .dstrm_valid    (stim.valid),
    .ustrm_state    (ustrm_state),
    .ustrm_protid   (ustrm_protid),
    .ustrm_data     (ustrm_data),
    .ustrm_dvalid   (ustrm_dvalid),
    .ustrm_crc      (ustrm_crc),
    .ustrm_valid    (ustrm_valid)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    abort_run($sformatf("Mismatch at %0t: %s expected %0h actual %0h",
                        $time, sig, exp_val, act_val));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  // Edges with raw online high, saturating once past the delay
  function automatic int next_run(input logic raw, input int run, input delay_t dly);
    if (!raw) begin
      return 0;
    end
    if (run > int'(dly)) begin
      return run;
    end
    return run + 1;
  endfunction

  // Online once raw was seen on more than dly edges, this one included
  function automatic logic online_next(input logic raw, input int run, input delay_t dly);
    return raw && (run + 1 > int'(dly));
  endfunction

  // Periodic strobe counted from the first online cycle
  assign stb_due = exp_tx_on &&
                   ((delay_z_value <= 16'd1) ? 1'b1 : (tx_phase % delay_z_value == 0));

  // Flit on the lanes, state in the low bits and valid on top
  assign exp_lane_bits = {exp_lane.valid, exp_lane.crc, exp_lane.dvalid,
                          exp_lane.data, exp_lane.protid, exp_lane.state};

  always @(posedge clk_wr) begin
    if (rst) begin
      tx_run    <= 0;
      rx_run    <= 0;
      tx_phase  <= 0;
      exp_tx_on <= 1'b0;
      exp_rx_on <= 1'b0;
      exp_stb   <= 1'b0;
      exp_mrk   <= '0;
      exp_flit  <= '0;
      exp_lane  <= '0;
      exp_rx    <= '0;
      exp_u     <= '0;
    end else begin
      tx_run    <= next_run(tx_online, tx_run, delay_y_value);
      exp_tx_on <= online_next(tx_online, tx_run, delay_y_value);
      rx_run    <= next_run(rx_online, rx_run, delay_x_value);
      exp_rx_on <= online_next(rx_online, rx_run, delay_x_value);
      tx_phase  <= exp_tx_on ? tx_phase + 1 : 0;
      // Sync bits land on the lanes one cycle later
      exp_stb   <= stb_due || tx_stb_userbit;
      exp_mrk   <= exp_tx_on ? tx_mrk_userbit : '0;
      // Packer, lanes, receive flit, unpacker
      exp_flit  <= exp_tx_on ? stim : '0;
      exp_lane  <= exp_flit;
      exp_rx    <= exp_lane;
      exp_u     <= exp_rx_on ? exp_rx : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  a_state: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_state == exp_u.state)
    else report_mismatch("ustrm_state", $sampled(exp_u.state), $sampled(ustrm_state));
  a_protid: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_protid == exp_u.protid)
    else report_mismatch("ustrm_protid", $sampled(exp_u.protid), $sampled(ustrm_protid));
  a_data: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_data == exp_u.data)
    else report_mismatch("ustrm_data", $sampled(exp_u.data), $sampled(ustrm_data));
  a_dvalid: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_dvalid == exp_u.dvalid)
    else report_mismatch("ustrm_dvalid", $sampled(exp_u.dvalid), $sampled(ustrm_dvalid));
  a_crc: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_crc == exp_u.crc)
    else report_mismatch("ustrm_crc", $sampled(exp_u.crc), $sampled(ustrm_crc));
  a_valid: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_valid == exp_u.valid)
    else report_mismatch("ustrm_valid", $sampled(exp_u.valid), $sampled(ustrm_valid));

  for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane_chk
    // Lane payload is its slice of the expected flit, zero while offline
    a_payload: assert property (@(posedge clk_wr) disable iff (rst)
      tx_lane[n][LANE_PAYLOAD-1:0] == exp_lane_bits[n*LANE_PAYLOAD +: LANE_PAYLOAD])
      else report_mismatch($sformatf("tx_phy%0d payload", n),
                           $sampled(exp_lane_bits[n*LANE_PAYLOAD +: LANE_PAYLOAD]),
                           $sampled(tx_lane[n][LANE_PAYLOAD-1:0]));
    a_stb: assert property (@(posedge clk_wr) disable iff (rst)
      tx_lane[n][STB_BIT] == exp_stb)
      else report_mismatch($sformatf("tx_phy%0d strobe", n), $sampled(exp_stb),
                           $sampled(tx_lane[n][STB_BIT]));
    a_mrk: assert property (@(posedge clk_wr) disable iff (rst)
      tx_lane[n][MRK_BIT] == exp_mrk[n])
      else report_mismatch($sformatf("tx_phy%0d marker", n), $sampled(exp_mrk[n]),
                           $sampled(tx_lane[n][MRK_BIT]));
  end

  // Run length guard
  always @(posedge clk_wr) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("Run timed out after %0d clock cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  // Random flits and user sync bits, 1 ns after each edge
  task automatic drive_cycles(input int cycles, input bit user_stb);
    repeat (cycles) begin
      @(posedge clk_wr);
      #1;
      stim.state     = $random(seed);
      stim.protid    = $random(seed);
      stim.data      = {$random(seed), $random(seed)};
      stim.crc       = $random(seed);
      stim.valid     = $random(seed);
      stim.dvalid    = stim.valid & $random(seed);
      tx_mrk_userbit = $random(seed);
      // Rare extra strobe from the user
      tx_stb_userbit = user_stb && (($random(seed) & 7) == 0);
    end
  endtask

  // One online and offline cycle of both link directions
  task automatic run_phase(input delay_t x, input delay_t y, input delay_t z);
    delay_x_value = x;
    delay_y_value = y;
    delay_z_value = z;
    drive_cycles(5, 1'b0);
    tx_online = 1'b1;
    drive_cycles(3, 1'b0);
    rx_online = 1'b1;
    drive_cycles(12, 1'b0);
    drive_cycles(200, 1'b1);
    tx_online      = 1'b0;
    tx_stb_userbit = 1'b0;
    // Pipeline drains, then receive drops too
    drive_cycles(20, 1'b0);
    rx_online = 1'b0;
    drive_cycles(10, 1'b0);
  endtask

  initial begin
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    stim           = '0;
    repeat (5) @(posedge clk_wr);
    #1;
    rst = 1'b0;
    run_phase(16'd3, 16'd2, 16'd4);
    run_phase(16'd0, 16'd5, 16'd7);
    drive_cycles(6, 1'b0);
    $display("All tests passed");
    $finish;
  end

endmodule

//--- hdl/link_top.sv
// Link top, master side
`timescale 1ns/1ns

module link_top import link_pkg::*; #(
  parameter bit MARKER_PERSISTENT = 1'b1
) (
  input  logic    clk_wr,
  input  logic    rst,

  // Control
  input  logic    tx_online,
  input  logic    rx_online,

  // Configuration
  input  delay_t  delay_x_value,
  input  delay_t  delay_y_value,
  input  delay_t  delay_z_value,
  input  mrk_t    tx_mrk_userbit,
  input  logic    tx_stb_userbit,

  // PHY lanes
  output lane_t   tx_phy0,
  output lane_t   tx_phy1,
  output lane_t   tx_phy2,
  output lane_t   tx_phy3,
  input  lane_t   rx_phy0,
  input  lane_t   rx_phy1,
  input  lane_t   rx_phy2,
  input  lane_t   rx_phy3,

  // Downstream user fields
  input  state_t  dstrm_state,
  input  protid_t dstrm_protid,
  input  data_t   dstrm_data,
  input  logic    dstrm_dvalid,
  input  crc_t    dstrm_crc,
  input  logic    dstrm_valid,

  // Upstream user fields
  output state_t  ustrm_state,
  output protid_t ustrm_protid,
  output data_t   ustrm_data,
  output logic    ustrm_dvalid,
  output crc_t    ustrm_crc,
  output logic    ustrm_valid
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////
  logic  tx_online_delay;
  logic  rx_online_delay;
  logic  tx_auto_stb;
  mrk_t  tx_auto_mrk;
  flit_t tx_flit;
  flit_t rx_flit;

  //////////////////////////////////////////////////////////////////////
  // Online delays, strobe and markers
  //////////////////////////////////////////////////////////////////////
  auto_sync #(
    .MARKER_PERSISTENT (MARKER_PERSISTENT)
  ) u_auto_sync (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_stb     (tx_auto_stb),
    .tx_auto_mrk     (tx_auto_mrk)
  );

  // Bypassed logic link, fields straight into the flit
  flit_packer u_flit_packer (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online_delay (tx_online_delay),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY lane slicing and reassembly
  //////////////////////////////////////////////////////////////////////
  lane_concat u_lane_concat (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .tx_flit     (tx_flit),
    .tx_auto_stb (tx_auto_stb),
    .tx_auto_mrk (tx_auto_mrk),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .tx_phy2     (tx_phy2),
    .tx_phy3     (tx_phy3),
    .rx_phy0     (rx_phy0),
    .rx_phy1     (rx_phy1),
    .rx_phy2     (rx_phy2),
    .rx_phy3     (rx_phy3),
    .rx_flit     (rx_flit)
  );

  // Receive flit back to upstream fields
  flit_unpacker u_flit_unpacker (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .rx_online_delay (rx_online_delay),
    .rx_flit         (rx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_valid     (ustrm_valid)
  );

endmodule

//--- hdl/flit_unpacker.sv
// Upstream flit unpacker
`timescale 1ns/1ns

module flit_unpacker import link_pkg::*; (
  input  logic    clk_wr,
  input  logic    rst,
  input  logic    rx_online_delay,
  input  flit_t   rx_flit,
  output state_t  ustrm_state,
  output protid_t ustrm_protid,
  output data_t   ustrm_data,
  output logic    ustrm_dvalid,
  output crc_t    ustrm_crc,
  output logic    ustrm_valid
);

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////
  // Receive side stays silent until word alignment time is over
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online_delay) begin
      ustrm_state  <= '0;
      ustrm_protid <= '0;
      ustrm_data   <= '0;
      ustrm_dvalid <= 1'b0;
      ustrm_crc    <= '0;
      ustrm_valid  <= 1'b0;
    end else begin
      // Low fields
      ustrm_state  <= rx_flit[FLD_STATE_LSB  +: $bits(state_t)];
      ustrm_protid <= rx_flit[FLD_PROTID_LSB +: $bits(protid_t)];
      // Payload and qualifier
      ustrm_data   <= rx_flit[FLD_DATA_LSB   +: $bits(data_t)];
      ustrm_dvalid <= rx_flit[FLD_DVALID_BIT];
      // CRC passed through untouched
      ustrm_crc    <= rx_flit[FLD_CRC_LSB    +: $bits(crc_t)];
      ustrm_valid  <= rx_flit[FLD_VALID_BIT];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  // Qualifier pairing must survive the whole link
  a_dvalid_out: assert property (@(posedge clk_wr) disable iff (rst)
    ustrm_dvalid |-> ustrm_valid)
    else $error("ustrm_dvalid without ustrm_valid");

endmodule

//--- lane_concat/lane_concat.sv
// PHY lane slicing and reassembly
`timescale 1ns/1ns

module lane_concat import link_pkg::*; (
  input  logic  clk_wr,
  input  logic  rst,

  // Transmit flit and sync bits
  input  flit_t tx_flit,
  input  logic  tx_auto_stb,
  input  mrk_t  tx_auto_mrk,

  // PHY lanes
  output lane_t tx_phy0,
  output lane_t tx_phy1,
  output lane_t tx_phy2,
  output lane_t tx_phy3,
  input  lane_t rx_phy0,
  input  lane_t rx_phy1,
  input  lane_t rx_phy2,
  input  lane_t rx_phy3,

  // Reassembled receive flit
  output flit_t rx_flit
);

  lane_t tx_lane_d [NUM_LANES];
  lane_t tx_lane_q [NUM_LANES];
  lane_t rx_lane   [NUM_LANES];
  flit_t rx_flit_d;

  //////////////////////////////////////////////////////////////////////
  // Transmit slicing
  //////////////////////////////////////////////////////////////////////
  for (genvar n = 0; n < NUM_LANES; n++) begin : g_tx_lane
    always_comb begin
      tx_lane_d[n] = '0;
      // Lane n carries its own 22 bit slice
      tx_lane_d[n][LANE_PAYLOAD-1:0] = tx_flit[n*LANE_PAYLOAD +: LANE_PAYLOAD];
      // Strobe shared by all lanes
      tx_lane_d[n][STB_BIT] = tx_auto_stb;
      // Marker per lane
      tx_lane_d[n][MRK_BIT] = tx_auto_mrk[n];
    end

    // Lanes idle at zero out of reset
    always_ff @(posedge clk_wr) begin
      if (rst) begin
        tx_lane_q[n] <= '0;
      end else begin
        tx_lane_q[n] <= tx_lane_d[n];
      end
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  //////////////////////////////////////////////////////////////////////
  // Receive reassembly
  //////////////////////////////////////////////////////////////////////
  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Strobe and marker dropped here, payload only
  always_comb begin
    rx_flit_d = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      rx_flit_d[n*LANE_PAYLOAD +: LANE_PAYLOAD] = rx_lane[n][LANE_PAYLOAD-1:0];
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_flit <= '0;
    end else begin
      rx_flit <= rx_flit_d;
    end
  end

endmodule

//--- hdl/flit_packer.sv
// Downstream flit packer
`timescale 1ns/1ns

module flit_packer import link_pkg::*; (
  input  logic    clk_wr,
  input  logic    rst,
  input  logic    tx_online_delay,
  input  state_t  dstrm_state,
  input  protid_t dstrm_protid,
  input  data_t   dstrm_data,
  input  logic    dstrm_dvalid,
  input  crc_t    dstrm_crc,
  input  logic    dstrm_valid,
  output flit_t   tx_flit
);

  //////////////////////////////////////////////////////////////////////
  // Field placement
  //////////////////////////////////////////////////////////////////////
  flit_t flit_d;

  always_comb begin
    flit_d = '0;
    // Low fields
    flit_d[FLD_STATE_LSB  +: $bits(state_t)]  = dstrm_state;
    flit_d[FLD_PROTID_LSB +: $bits(protid_t)] = dstrm_protid;
    // Payload and its qualifier
    flit_d[FLD_DATA_LSB   +: $bits(data_t)]   = dstrm_data;
    flit_d[FLD_DVALID_BIT]                    = dstrm_dvalid;
    // CRC is carried opaque
    flit_d[FLD_CRC_LSB    +: $bits(crc_t)]    = dstrm_crc;
    flit_d[FLD_VALID_BIT]                     = dstrm_valid;
  end

  //////////////////////////////////////////////////////////////////////
  // Flit register
  //////////////////////////////////////////////////////////////////////
  // Nothing reaches the lanes until alignment time is over
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_flit <= '0;
    end else if (!tx_online_delay) begin
      tx_flit <= '0;
    end else begin
      tx_flit <= flit_d;
    end
  end

  // Data qualifier only inside a valid flit
  a_dvalid_in: assert property (@(posedge clk_wr) disable iff (rst)
    dstrm_dvalid |-> dstrm_valid)
    else $error("dstrm_dvalid without dstrm_valid");

endmodule

//--- auto_sync/auto_sync.sv
// Link auto sync
`timescale 1ns/1ns

module auto_sync import link_pkg::*; #(
  parameter bit MARKER_PERSISTENT = 1'b1
) (
  input  logic   clk_wr,
  input  logic   rst,
  input  logic   tx_online,
  input  logic   rx_online,
  // Receive delay, transmit delay, strobe period
  input  delay_t delay_x_value,
  input  delay_t delay_y_value,
  input  delay_t delay_z_value,
  input  mrk_t   tx_mrk_userbit,
  input  logic   tx_stb_userbit,
  output logic   tx_online_delay,
  output logic   rx_online_delay,
  output logic   tx_auto_stb,
  output mrk_t   tx_auto_mrk
);

  //////////////////////////////////////////////////////////////////////
  // Online delay counters
  //////////////////////////////////////////////////////////////////////
  // Channel 0 is transmit, channel 1 is receive
  logic   online_raw [2];
  delay_t online_dly [2];
  delay_t dly_cnt    [2];
  logic   online_q   [2];

  assign online_raw[0] = tx_online;
  assign online_raw[1] = rx_online;
  assign online_dly[0] = delay_y_value;
  assign online_dly[1] = delay_x_value;

  for (genvar i = 0; i < 2; i++) begin : g_delay
    always_ff @(posedge clk_wr) begin
      // Any drop of the raw online restarts the wait
      if (rst || !online_raw[i]) begin
        dly_cnt[i]  <= '0;
        online_q[i] <= 1'b0;
      end else if (dly_cnt[i] >= online_dly[i]) begin
        online_q[i] <= 1'b1;
      end else begin
        dly_cnt[i] <= dly_cnt[i] + 16'd1;
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  //////////////////////////////////////////////////////////////////////
  // Periodic strobe
  //////////////////////////////////////////////////////////////////////
  delay_t per_cnt;
  logic   per_hit;

  // Count sits at zero while offline, so first online cycle strobes
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      per_cnt <= '0;
    end else if (delay_z_value <= 16'd1 || per_cnt == delay_z_value - 16'd1) begin
      per_cnt <= '0;
    end else begin
      per_cnt <= per_cnt + 16'd1;
    end
  end

  assign per_hit     = tx_online_delay && (per_cnt == '0);
  // User strobe is always let through
  assign tx_auto_stb = per_hit || tx_stb_userbit;

  // Markers held every online cycle, or only on strobe cycles
  always_comb begin
    if (MARKER_PERSISTENT) begin
      tx_auto_mrk = tx_online_delay ? tx_mrk_userbit : '0;
    end else begin
      tx_auto_mrk = per_hit ? tx_mrk_userbit : '0;
    end
  end

  // Auto strobe only ever comes from an online transmitter
  a_stb_offline: assert property (@(posedge clk_wr) disable iff (rst)
    (tx_auto_stb && !tx_online_delay) |-> tx_stb_userbit)
    else $error("auto strobe while transmit offline");

  // Receive online only rises after raw online was seen
  a_rx_rise: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_online_delay) |-> $past(rx_online))
    else $error("rx_online_delay rose without rx_online");

endmodule

//--- common/link_pkg.sv
// Die-to-die link shared definitions

package link_pkg;

  // Lane and flit geometry
  localparam int NUM_LANES    = 4;
  localparam int LANE_PAYLOAD = 22;
  // Payload plus strobe and marker
  localparam int LANE_WIDTH   = LANE_PAYLOAD + 2;
  localparam int FLIT_WIDTH   = NUM_LANES * LANE_PAYLOAD;

  // Strobe and marker positions inside each lane
  localparam int STB_BIT = LANE_PAYLOAD;
  localparam int MRK_BIT = LANE_PAYLOAD + 1;

  // User field types
  typedef logic [3:0]  state_t;
  typedef logic [1:0]  protid_t;
  typedef logic [63:0] data_t;
  typedef logic [15:0] crc_t;

  // Link level types
  typedef logic [FLIT_WIDTH-1:0] flit_t;
  typedef logic [LANE_WIDTH-1:0] lane_t;
  typedef logic [15:0]           delay_t;
  typedef logic [NUM_LANES-1:0]  mrk_t;

  //////////////////////////////////////////////////////////////////////
  // Flit layout, low bit first
  //////////////////////////////////////////////////////////////////////
  localparam int FLD_STATE_LSB  = 0;
  localparam int FLD_PROTID_LSB = FLD_STATE_LSB + $bits(state_t);
  localparam int FLD_DATA_LSB   = FLD_PROTID_LSB + $bits(protid_t);
  localparam int FLD_DVALID_BIT = FLD_DATA_LSB + $bits(data_t);
  localparam int FLD_CRC_LSB    = FLD_DVALID_BIT + 1;
  localparam int FLD_VALID_BIT  = FLD_CRC_LSB + $bits(crc_t);

  // Valid sits in the top bit of the flit
  localparam int FLD_TOTAL = FLD_VALID_BIT + 1;

endpackage
